//--- flist.f
common/fetch_pkg.sv
hw/fetch_pc.sv
icache/icache.sv
hw/inst_split.sv
hw/fetch_top.sv
verification/imem_model.sv
verification/fetch_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch testbench with Verilator, result taken from sim.log
rm -f sim.log &&
verilator --binary --assert --top-module fetch_tb -f flist.f -o fetch_sim &&
./obj_dir/fetch_sim | tee sim.log ||
{ echo "build or simulation failed"; exit 1; }

grep -q "all tests passed" sim.log &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

//--- verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  logic                  clock;
  logic                  reset;
  logic                  redirect;
  logic [31:0]           redirect_pc;
  logic                  stall;
  fetch_pkg::mem_req_t   mem_req;
  fetch_pkg::mem_rsp_t   mem_rsp;
  fetch_pkg::fetch_out_t fetch_out;

  int          errors = 0;
  int          cycles = 0;
  int          out_count = 0;
  int          refusals = 0;
  int          loop_seen = 0;
  // Reference PC and a redirect still to be applied to it
  logic [31:0] exp_pc = fetch_pkg::reset_pc;
  logic        jump_pending = 1'b0;
  logic [31:0] jump_target = 32'd0;
  logic        retry_expected = 1'b0;
  logic [31:0] retry_addr = 32'd0;
  logic        first_cycle = 1'b1;
  logic        data_seen = 1'b0;
  logic        loop_armed = 1'b0;
  logic        loop_done = 1'b0;
  logic        grant_seen = 1'b0;
  logic [31:0] grant_addr = 32'd0;

  // Port names match the local signals
  fetch_top i_fetch_top (.*);
  imem_model i_imem_model (.*);

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'hA5A5_0000;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    errors++;
    $display("[ERROR] %s = %h, expected %h at cycle %0d", name, got, want, cycles);
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic jump_to(input logic [31:0] target);
    redirect    = 1'b1;
    redirect_pc = target;
    next_cycle();
    redirect = 1'b0;
  endtask

  task automatic wait_outputs(input int n);
    int goal;
    goal = out_count + n;
    while (out_count < goal) begin
      next_cycle();
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Cycle limit covers about 120 misses at the worst retry rate
  always @(posedge clock) begin
    cycles++;
    if (cycles == 3000) begin
      $display("Timeout after %0d cycles with %0d instructions out", cycles, out_count);
      $display("tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks sampled at the falling edge
  //////////////////////////////////////////////////////////////////////

  // Output of a stalled cycle is never valid
  assert property (@(posedge clock) disable iff (reset) $past(stall) |-> !fetch_out.valid)
  else report_mismatch("fetch_out.valid", 32'(fetch_out.valid), 32'd0);

  always @(negedge clock) begin
    if (!reset) begin
      if (first_cycle) begin
        assert (mem_req.cmd == fetch_pkg::bus_none)
        else report_mismatch("mem_req.cmd", 32'(mem_req.cmd), 32'(fetch_pkg::bus_none));
        first_cycle = 1'b0;
      end
      // Nothing reaches decode before the first fill
      assert (data_seen || !fetch_out.valid)
      else report_mismatch("fetch_out.valid", 32'(fetch_out.valid), 32'd0);
      if (mem_rsp.tag != '0) data_seen = 1'b1;
      if (fetch_out.valid) begin
        assert (fetch_out.pc == exp_pc)
        else report_mismatch("fetch_out.pc", fetch_out.pc, exp_pc);
        assert (fetch_out.insn == expected_word(exp_pc))
        else report_mismatch("fetch_out.insn", fetch_out.insn, expected_word(exp_pc));
        exp_pc = exp_pc + 32'd4;
        out_count++;
      end
      // Instruction accepted in the redirect cycle still comes out first
      if (jump_pending) exp_pc = jump_target;
      jump_pending = redirect;
      jump_target  = redirect_pc;
      // Second pass over cached code is silent on the bus and gapless
      if (loop_armed) begin
        assert (mem_req.cmd == fetch_pkg::bus_none)
        else report_mismatch("mem_req.cmd", 32'(mem_req.cmd), 32'(fetch_pkg::bus_none));
        if (loop_seen > 0) begin
          assert (fetch_out.valid)
          else report_mismatch("fetch_out.valid", 32'(fetch_out.valid), 32'd1);
        end
        if (fetch_out.valid) loop_seen++;
        if (loop_seen == 16) begin
          loop_armed = 1'b0;
          loop_done  = 1'b1;
        end
      end
      // A refused load comes back next cycle for the same line
      if (retry_expected) begin
        assert (mem_req.cmd == fetch_pkg::bus_load)
        else report_mismatch("mem_req.cmd", 32'(mem_req.cmd), 32'(fetch_pkg::bus_load));
        assert (mem_req.addr == retry_addr)
        else report_mismatch("mem_req.addr", mem_req.addr, retry_addr);
      end
      retry_expected = (mem_req.cmd == fetch_pkg::bus_load) && (mem_rsp.response == '0) &&
                       !redirect;
      retry_addr = mem_req.addr;
      if (retry_expected) refusals++;
      if ((mem_req.cmd == fetch_pkg::bus_load) && (mem_rsp.response != '0)) begin
        grant_seen = 1'b1;
        grant_addr = mem_req.addr;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset       = 1'b1;
    redirect    = 1'b0;
    redirect_pc = 32'd0;
    stall       = 1'b0;
    repeat (16) @(posedge clock);
    #1 reset = 1'b0;
    // First pass fills eight lines, then loop back over them
    wait_outputs(16);
    jump_to(fetch_pkg::reset_pc);
    loop_armed = 1'b1;
    while (!loop_done) next_cycle();
    // Leave a granted miss for the same index with another tag
    grant_seen = 1'b0;
    while (!grant_seen) next_cycle();
    jump_to(grant_addr + 32'h104);
    wait_outputs(8);
    // Stall over hits, then a redirect inside a stall
    jump_to(fetch_pkg::reset_pc);
    wait_outputs(3);
    stall = 1'b1;
    repeat (4) next_cycle();
    stall = 1'b0;
    wait_outputs(2);
    stall = 1'b1;
    next_cycle();
    jump_to(32'h120);
    stall = 1'b0;
    wait_outputs(6);
    // Fill runs on under a long stall
    jump_to(32'h600);
    stall = 1'b1;
    repeat (20) next_cycle();
    stall = 1'b0;
    wait_outputs(4);
    repeat (4) next_cycle();
    assert (refusals > 0)
    else begin
      errors++;
      $display("Memory never refused a load, retry path not exercised");
    end
    $display("Done: %0d instructions, %0d refusals, %0d errors", out_count, refusals, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verification/imem_model.sv
`timescale 1ns/1ps

module imem_model (
  input  logic                clock,
  input  logic                reset,
  input  fetch_pkg::mem_req_t mem_req,
  output fetch_pkg::mem_rsp_t mem_rsp
);

  // Busy draws follow a fixed seed
  integer      seed = 32'h5389f3c5;
  logic        busy;
  logic        grant;
  logic [3:0]  next_tag;
  // Return pipeline, stage 11 drives the data bus
  logic [3:0]  pipe_tag [12];
  logic [31:0] pipe_addr [12];

  // Word content as a function of its byte address
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'hA5A5_0000;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Response and data bus
  //////////////////////////////////////////////////////////////////////

  // Tag granted in the cycle of the load, zero when busy or idle
  assign grant = (mem_req.cmd == fetch_pkg::bus_load) && !busy;
  assign mem_rsp = '{
    response: grant ? next_tag : 4'd0,
    tag:      pipe_tag[11],
    data:     {word_at(pipe_addr[11] + 32'd4), word_at(pipe_addr[11])}
  };

  always @(posedge clock) begin
    if (reset) begin
      busy     <= 1'b0;
      next_tag <= 4'd1;
      for (int i = 0; i < 12; i++) begin
        pipe_tag[i]  <= 4'd0;
        pipe_addr[i] <= 32'd0;
      end
    end else begin
      // Roughly one cycle in three turns a load away
      busy <= ($unsigned($random(seed)) % 3) == 0;
      // Tags 1 to 15 in rotation
      if (grant) begin
        next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
      // Granted line comes back 12 cycles later
      pipe_tag[0]  <= grant ? next_tag : 4'd0;
      pipe_addr[0] <= mem_req.addr;
      for (int i = 1; i < 12; i++) begin
        pipe_tag[i]  <= pipe_tag[i-1];
        pipe_addr[i] <= pipe_addr[i-1];
      end
    end
  end

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic                       clock,
  input  logic                       reset,
  // From execute, a taken branch or jump
  input  logic                       redirect,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc,
  // From decode
  input  logic                       stall,
  // Instruction memory port
  input  fetch_pkg::mem_rsp_t        mem_rsp,
  output fetch_pkg::mem_req_t        mem_req,
  // To decode
  output fetch_pkg::fetch_out_t      fetch_out
);

  //////////////////////////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////////////////////////

  logic [fetch_pkg::xlen-1:0] fetch_addr;
  fetch_pkg::cache_line_u     line;
  logic                       hit;
  logic                       accept;

  // PC producer
  fetch_pc i_fetch_pc (
    .clock       (clock),
    .reset       (reset),
    .accept      (accept),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_addr  (fetch_addr)
  );

  // Blocking instruction cache
  icache i_icache (
    .clock      (clock),
    .reset      (reset),
    .fetch_addr (fetch_addr),
    .mem_rsp    (mem_rsp),
    .mem_req    (mem_req),
    .line       (line),
    .hit        (hit)
  );

  // Word select and decode register
  inst_split i_inst_split (
    .clock      (clock),
    .reset      (reset),
    .line       (line),
    .hit        (hit),
    .stall      (stall),
    .fetch_addr (fetch_addr),
    .accept     (accept),
    .fetch_out  (fetch_out)
  );

endmodule

//--- hw/inst_split.sv
`timescale 1ns/1ps

module inst_split (
  input  logic                       clock,
  input  logic                       reset,
  // Line and hit straight from the cache lookup
  input  fetch_pkg::cache_line_u     line,
  input  logic                       hit,
  // Decode cannot take an instruction
  input  logic                       stall,
  input  logic [fetch_pkg::xlen-1:0] fetch_addr,
  output logic                       accept,
  output fetch_pkg::fetch_out_t      fetch_out
);

  logic [31:0]                sel_insn;
  logic                       out_valid;
  logic [fetch_pkg::xlen-1:0] out_pc;
  logic [31:0]                out_insn;

  //////////////////////////////////////////////////////////////////////
  // Slot select
  //////////////////////////////////////////////////////////////////////

  // Instruction leaves only on a hit with decode ready
  assign accept = hit && !stall;

  // Address bit 2 picks the upper or lower word of the line
  assign sel_insn = line.insn[fetch_addr[fetch_pkg::offset_bits-1]];

  // Valid follows accept one cycle later
  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= accept;
    end
  end

  // Payload, meaningful only with valid
  always_ff @(posedge clock) begin
    out_pc   <= fetch_addr;
    out_insn <= sel_insn;
  end

  assign fetch_out = '{valid: out_valid, pc: out_pc, insn: out_insn};

  // Decode sees nothing right after reset, whatever the cache says
  assert property (@(posedge clock) $past(reset) |-> !fetch_out.valid)
  else $error("[ERROR] inst_split fetch_out.valid=%h after reset", fetch_out.valid);

endmodule

//--- icache/icache.sv
`timescale 1ns/1ps

module icache (
  input  logic                       clock,
  input  logic                       reset,
  // Lookup address from the PC register
  input  logic [fetch_pkg::xlen-1:0] fetch_addr,
  input  fetch_pkg::mem_rsp_t        mem_rsp,
  output fetch_pkg::mem_req_t        mem_req,
  output fetch_pkg::cache_line_u     line,
  output logic                       hit
);

  // Direct-mapped line store
  fetch_pkg::icache_entry_t cache_mem [fetch_pkg::cache_lines];

  // Cache tag and index of this cycle and the last
  logic [fetch_pkg::tag_bits-1:0]     current_tag;
  logic [fetch_pkg::tag_bits-1:0]     last_tag;
  logic [fetch_pkg::index_bits-1:0]   current_index;
  logic [fetch_pkg::index_bits-1:0]   last_index;
  // Memory tag of the fill we wait on
  logic [fetch_pkg::mem_tag_bits-1:0] current_mem_tag;
  // Miss still without a response tag
  logic                               miss_outstanding;
  logic                               got_mem_data;
  logic                               changed_addr;
  logic                               update_mem_tag;
  logic                               unanswered_miss;

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////

  assign current_index = fetch_addr[fetch_pkg::offset_bits +: fetch_pkg::index_bits];
  assign current_tag =
    fetch_addr[fetch_pkg::offset_bits + fetch_pkg::index_bits +: fetch_pkg::tag_bits];

  // Same-cycle read straight from the array
  assign line = cache_mem[current_index].line;
  assign hit  = cache_mem[current_index].valid &&
                (cache_mem[current_index].tag == current_tag);

  //////////////////////////////////////////////////////////////////////
  // Miss handling
  //////////////////////////////////////////////////////////////////////

  // Data on the bus belongs to our request and the address still wants it
  assign got_mem_data = !changed_addr && (current_mem_tag != '0) &&
                        (mem_rsp.tag == current_mem_tag);

  // New address abandons whatever was pending
  assign changed_addr = (current_index != last_index) || (current_tag != last_tag);

  // Reload the held tag on an address change, while asking, and after a fill
  // memory returns a zero response whenever no command was sent
  assign update_mem_tag = changed_addr || miss_outstanding || got_mem_data;

  // Fresh miss, or a load the memory turned away this cycle
  assign unanswered_miss = changed_addr ? !hit
                                        : miss_outstanding && (mem_rsp.response == '0);

  // Load repeats until a response tag comes back
  assign mem_req = '{
    cmd:  (miss_outstanding && !changed_addr) ? fetch_pkg::bus_load : fetch_pkg::bus_none,
    addr: {fetch_addr[fetch_pkg::xlen-1:fetch_pkg::offset_bits],
           {fetch_pkg::offset_bits{1'b0}}}
  };

  // Control state
  always_ff @(posedge clock) begin
    if (reset) begin
      // All ones so the first cycle looks like a new address
      last_index       <= '1;
      last_tag         <= '1;
      current_mem_tag  <= '0;
      miss_outstanding <= 1'b0;
    end else begin
      last_index       <= current_index;
      last_tag         <= current_tag;
      miss_outstanding <= unanswered_miss;
      if (update_mem_tag) begin
        current_mem_tag <= mem_rsp.response;
      end
    end
  end

  // Reset invalidates every line
  // A matching data tag fills the line
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < fetch_pkg::cache_lines; i++) begin
        cache_mem[i].valid <= 1'b0;
      end
    end else if (got_mem_data) begin
      cache_mem[current_index].line.raw <= mem_rsp.data;
      cache_mem[current_index].tag      <= current_tag;
      cache_mem[current_index].valid    <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // A line that hits never produces bus traffic
  assert property (@(posedge clock) disable iff (reset)
    (hit && !changed_addr) |-> (mem_req.cmd == fetch_pkg::bus_none))
  else $error("[ERROR] icache mem_req.cmd=%h on hit, addr=%h", mem_req.cmd, fetch_addr);

  // Never asking for a tag while holding one
  assert property (@(posedge clock) disable iff (reset)
    !(miss_outstanding && (current_mem_tag != '0)))
  else $error("[ERROR] icache current_mem_tag=%h with load outstanding", current_mem_tag);

  // Loads always go out line aligned
  assert property (@(posedge clock) disable iff (reset)
    (mem_req.cmd == fetch_pkg::bus_load) |-> (mem_req.addr[fetch_pkg::offset_bits-1:0] == '0))
  else $error("[ERROR] icache mem_req.addr=%h not line aligned", mem_req.addr);

endmodule

//--- hw/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc (
  input  logic                       clock,
  input  logic                       reset,
  // Instruction taken by the consumer this cycle
  input  logic                       accept,
  // Control transfer from a later stage
  input  logic                       redirect,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc,
  output logic [fetch_pkg::xlen-1:0] fetch_addr
);

  logic [fetch_pkg::xlen-1:0] pc;
  logic [fetch_pkg::xlen-1:0] next_pc;

  //////////////////////////////////////////////////////////////////////
  // Next PC selection
  //////////////////////////////////////////////////////////////////////

  // Redirect wins over a normal step
  // Without either the PC holds, which covers stall and miss
  always_comb begin
    next_pc = pc;
    if (redirect) begin
      next_pc = redirect_pc;
    end else if (accept) begin
      next_pc = pc + 32'd4;
    end
  end

  // Program counter register
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= fetch_pkg::reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  // Current PC goes straight to the cache lookup
  assign fetch_addr = pc;

  // Word alignment holds for every target a later stage sends
  assert property (@(posedge clock) disable iff (reset)
    fetch_addr[1:0] == 2'b00)
  else $error("[ERROR] fetch_pc fetch_addr=%h not word aligned", fetch_addr);

endmodule

//--- common/fetch_pkg.sv
package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // Fetch geometry
  //////////////////////////////////////////////////////////////////////

  // Address and PC width
  localparam int xlen = 32;
  // Bytes per cache line
  localparam int line_bytes = 8;
  // Low address bits that select a byte inside a line
  localparam int offset_bits = $clog2(line_bytes);
  localparam int cache_lines = 32;
  localparam int index_bits = 5;
  // Cache covers a 16-bit space so bits 15..8 form the tag
  localparam int tag_bits = 8;
  // Memory transaction tag, zero means no response
  localparam int mem_tag_bits = 4;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0100;

  //////////////////////////////////////////////////////////////////////
  // Memory bus
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_cmd_e;

  // One line seen whole or as two instruction slots
  // Slot 0 sits at the lower address
  typedef union packed {
    logic [63:0]      raw;
    logic [1:0][31:0] insn;
  } cache_line_u;

  typedef struct packed {
    cache_line_u         line;
    logic [tag_bits-1:0] tag;
    logic                valid;
  } icache_entry_t;

  typedef struct packed {
    bus_cmd_e        cmd;
    logic [xlen-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [mem_tag_bits-1:0] response;
    logic [mem_tag_bits-1:0] tag;
    logic [63:0]             data;
  } mem_rsp_t;

  // Instruction handed to decode
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [31:0]     insn;
  } fetch_out_t;

endpackage
